// File: hdl/tart_pkg.sv
package tart_pkg;

	// ------------------------------------------------------------------------
	// Register map
	// ------------------------------------------------------------------------

	// Word addresses, byte offset bits stripped
	typedef enum logic [4:0]
	{
		REG_CONTROL      = 5'd0,
		REG_SAMPLE_COUNT = 5'd1,
		REG_SNAPSHOT     = 5'd2,
		REG_SCRATCH      = 5'd3
	} reg_addr_e;

	// Bit positions inside CONTROL
	localparam integer CTRL_LED_BIT     = 0;
	localparam integer CTRL_CAPTURE_BIT = 1;
	// Write-only, always reads back as 0
	localparam integer CTRL_CLEAR_BIT   = 2;

	// ------------------------------------------------------------------------
	// AXI4-Lite response codes
	// ------------------------------------------------------------------------

	typedef enum logic [1:0]
	{
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} axi_resp_e;

	// ------------------------------------------------------------------------
	// Channel state machines
	// ------------------------------------------------------------------------

	// Write channel, idle or holding BVALID
	typedef enum logic [0:0]
	{
		WR_IDLE = 1'b0,
		WR_RESP = 1'b1
	} wr_state_e;

	// Read channel, idle or holding RVALID
	typedef enum logic [0:0]
	{
		RD_IDLE = 1'b0,
		RD_DATA = 1'b1
	} rd_state_e;

endpackage

// File: hdl/axi_write_channel.sv
`timescale 1ns/1ns

module axi_write_channel #(
	parameter integer DATA_WIDTH = 32,
	parameter integer ADDR_WIDTH = 7
)
(
	input  logic                        S_AXI_ACLK,
	input  logic                        S_AXI_ARESETN,
	input  logic [ADDR_WIDTH-1:0]       S_AXI_AWADDR,
	input  logic                        S_AXI_AWVALID,
	output logic                        S_AXI_AWREADY,
	input  logic [DATA_WIDTH-1:0]       S_AXI_WDATA,
	input  logic [(DATA_WIDTH/8)-1:0]   S_AXI_WSTRB,
	input  logic                        S_AXI_WVALID,
	output logic                        S_AXI_WREADY,
	output tart_pkg::axi_resp_e         S_AXI_BRESP,
	output logic                        S_AXI_BVALID,
	input  logic                        S_AXI_BREADY,
	output logic                        capture_enable,
	output logic                        count_clear,
	output logic [DATA_WIDTH-1:0]       ctrl_value,
	output logic [DATA_WIDTH-1:0]       scratch_value
);

	// Byte offset bits, 2 for 32-bit and 3 for 64-bit data
	localparam integer ADDR_LSB   = (DATA_WIDTH / 32) + 1;
	localparam integer WORD_BITS  = ADDR_WIDTH - ADDR_LSB;
	localparam integer STRB_WIDTH = DATA_WIDTH / 8;

	tart_pkg::wr_state_e   wr_state;
	tart_pkg::axi_resp_e   bresp;
	tart_pkg::reg_addr_e   wr_addr;
	logic                  awready;
	logic                  wready;
	logic                  wr_en;
	logic                  wr_writable;
	logic                  clear_req;
	logic [WORD_BITS-1:0]  aw_word;
	logic [DATA_WIDTH-1:0] ctrl_reg;
	logic [DATA_WIDTH-1:0] scratch_reg;
	logic [DATA_WIDTH-1:0] ctrl_merged;
	logic [DATA_WIDTH-1:0] scratch_merged;

	// Replace only the strobed byte lanes of a register
	function automatic logic [DATA_WIDTH-1:0] merge_bytes(
		input logic [DATA_WIDTH-1:0] old_value,
		input logic [DATA_WIDTH-1:0] new_value,
		input logic [STRB_WIDTH-1:0] strb
	);
		logic [DATA_WIDTH-1:0] result;
		result = old_value;
		for (int b = 0; b < STRB_WIDTH; b++)
		begin
			if (strb[b])
			begin
				result[b*8 +: 8] = new_value[b*8 +: 8];
			end
		end
		return result;
	endfunction

	// ------------------------------------------------------------------------
	// Address decode and byte merge
	// ------------------------------------------------------------------------

	// Master holds address and data until the ready cycle
	assign aw_word     = S_AXI_AWADDR[ADDR_WIDTH-1:ADDR_LSB];
	assign wr_addr     = tart_pkg::reg_addr_e'(aw_word);
	assign wr_en       = awready && wready && S_AXI_AWVALID && S_AXI_WVALID;
	assign wr_writable = (wr_addr == tart_pkg::REG_CONTROL) ||
	                     (wr_addr == tart_pkg::REG_SCRATCH);

	// CLEAR needs its byte strobed and the bit set
	assign clear_req = (wr_addr == tart_pkg::REG_CONTROL) &&
	                   S_AXI_WSTRB[tart_pkg::CTRL_CLEAR_BIT / 8] &&
	                   S_AXI_WDATA[tart_pkg::CTRL_CLEAR_BIT];

	always_comb
	begin
		ctrl_merged = merge_bytes(ctrl_reg, S_AXI_WDATA, S_AXI_WSTRB);
		// Never stored, becomes a pulse instead
		ctrl_merged[tart_pkg::CTRL_CLEAR_BIT] = 1'b0;
	end

	assign scratch_merged = merge_bytes(scratch_reg, S_AXI_WDATA, S_AXI_WSTRB);

	// ------------------------------------------------------------------------
	// Handshake FSM
	// ------------------------------------------------------------------------

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			wr_state <= tart_pkg::WR_IDLE;
			awready  <= 1'b0;
			wready   <= 1'b0;
			bresp    <= tart_pkg::RESP_OKAY;
		end
		else
		begin
			case (wr_state)
				tart_pkg::WR_IDLE:
				begin
					if (awready)
					begin
						// Ready lasts exactly one cycle
						awready <= 1'b0;
						wready  <= 1'b0;
						if (wr_en)
						begin
							bresp    <= wr_writable ? tart_pkg::RESP_OKAY : tart_pkg::RESP_SLVERR;
							wr_state <= tart_pkg::WR_RESP;
						end
					end
					else if (S_AXI_AWVALID && S_AXI_WVALID)
					begin
						awready <= 1'b1;
						wready  <= 1'b1;
					end
				end
				tart_pkg::WR_RESP:
				begin
					// No new write until the response is taken
					if (S_AXI_BREADY)
					begin
						wr_state <= tart_pkg::WR_IDLE;
					end
				end
				default:
				begin
					wr_state <= tart_pkg::WR_IDLE;
				end
			endcase
		end
	end

	// ------------------------------------------------------------------------
	// Register file and clear pulse
	// ------------------------------------------------------------------------

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			ctrl_reg    <= '0;
			scratch_reg <= '0;
			count_clear <= 1'b0;
		end
		else
		begin
			// One cycle pulse, the cycle after acceptance
			count_clear <= wr_en && clear_req;
			if (wr_en)
			begin
				case (wr_addr)
					tart_pkg::REG_CONTROL: ctrl_reg <= ctrl_merged;
					tart_pkg::REG_SCRATCH: scratch_reg <= scratch_merged;
					// Read-only and unmapped words stay unchanged
					default: ;
				endcase
			end
		end
	end

	assign S_AXI_AWREADY  = awready;
	assign S_AXI_WREADY   = wready;
	assign S_AXI_BRESP    = bresp;
	assign S_AXI_BVALID   = (wr_state == tart_pkg::WR_RESP);
	assign capture_enable = ctrl_reg[tart_pkg::CTRL_CAPTURE_BIT];
	assign ctrl_value     = ctrl_reg;
	assign scratch_value  = scratch_reg;

endmodule

// File: hdl/antenna_capture.sv
`timescale 1ns/1ns

module antenna_capture #(
	parameter integer ANTENNAE   = 24,
	parameter integer DATA_WIDTH = 32
)
(
	input  logic                  S_AXI_ACLK,
	input  logic                  S_AXI_ARESETN,
	input  logic [ANTENNAE-1:0]   antenna,
	input  logic                  sample_tick,
	input  logic                  capture_enable,
	input  logic                  count_clear,
	output logic [ANTENNAE-1:0]   snapshot,
	output logic [DATA_WIDTH-1:0] sample_count
);

	logic [ANTENNAE-1:0]   snapshot_reg;
	logic [DATA_WIDTH-1:0] count_reg;
	logic                  take_sample;

	// ------------------------------------------------------------------------
	// Sample gating
	// ------------------------------------------------------------------------

	// Tick only counts while capture is on
	// Clear wins over a tick in the same cycle
	assign take_sample = sample_tick && capture_enable && !count_clear;

	// ------------------------------------------------------------------------
	// Snapshot and counter
	// ------------------------------------------------------------------------

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			snapshot_reg <= '0;
			count_reg    <= '0;
		end
		else
		begin
			if (count_clear)
			begin
				// Snapshot kept, only the count restarts
				count_reg <= '0;
			end
			else if (take_sample)
			begin
				// Wraps at full width
				count_reg <= count_reg + 1'b1;
			end

			if (take_sample)
			begin
				snapshot_reg <= antenna;
			end
		end
	end

	// Both visible the cycle after the tick
	assign snapshot     = snapshot_reg;
	assign sample_count = count_reg;

endmodule

// File: hdl/axi_read_channel.sv
`timescale 1ns/1ns

module axi_read_channel #(
	parameter integer ANTENNAE   = 24,
	parameter integer DATA_WIDTH = 32,
	parameter integer ADDR_WIDTH = 7
)
(
	input  logic                  S_AXI_ACLK,
	input  logic                  S_AXI_ARESETN,
	input  logic [ADDR_WIDTH-1:0] S_AXI_ARADDR,
	input  logic                  S_AXI_ARVALID,
	output logic                  S_AXI_ARREADY,
	output logic [DATA_WIDTH-1:0] S_AXI_RDATA,
	output tart_pkg::axi_resp_e   S_AXI_RRESP,
	output logic                  S_AXI_RVALID,
	input  logic                  S_AXI_RREADY,
	input  logic [DATA_WIDTH-1:0] ctrl_value,
	input  logic [DATA_WIDTH-1:0] scratch_value,
	input  logic [ANTENNAE-1:0]   snapshot,
	input  logic [DATA_WIDTH-1:0] sample_count
);

	// Byte offset bits, as in the write channel
	localparam integer ADDR_LSB  = (DATA_WIDTH / 32) + 1;
	localparam integer WORD_BITS = ADDR_WIDTH - ADDR_LSB;

	tart_pkg::rd_state_e   rd_state;
	tart_pkg::reg_addr_e   rd_addr;
	tart_pkg::axi_resp_e   rresp;
	tart_pkg::axi_resp_e   mux_resp;
	logic                  arready;
	logic [WORD_BITS-1:0]  ar_word;
	logic [DATA_WIDTH-1:0] rdata;
	logic [DATA_WIDTH-1:0] mux_data;

	// ------------------------------------------------------------------------
	// Register read mux
	// ------------------------------------------------------------------------

	assign rd_addr = tart_pkg::reg_addr_e'(ar_word);

	always_comb
	begin
		mux_resp = tart_pkg::RESP_OKAY;
		case (rd_addr)
			tart_pkg::REG_CONTROL:      mux_data = ctrl_value;
			tart_pkg::REG_SAMPLE_COUNT: mux_data = sample_count;
			// Zero-extended to the bus width
			tart_pkg::REG_SNAPSHOT:     mux_data = DATA_WIDTH'(snapshot);
			tart_pkg::REG_SCRATCH:      mux_data = scratch_value;
			default:
			begin
				mux_data = '0;
				mux_resp = tart_pkg::RESP_SLVERR;
			end
		endcase
	end

	// ------------------------------------------------------------------------
	// Handshake FSM
	// ------------------------------------------------------------------------

	// Address latched on acceptance, data taken in the ready cycle
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			ar_word <= '0;
			rdata   <= '0;
		end
		else
		begin
			if (!arready && S_AXI_ARVALID && rd_state == tart_pkg::RD_IDLE)
			begin
				ar_word <= S_AXI_ARADDR[ADDR_WIDTH-1:ADDR_LSB];
			end
			if (arready && S_AXI_ARVALID)
			begin
				rdata <= mux_data;
			end
		end
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			rd_state <= tart_pkg::RD_IDLE;
			arready  <= 1'b0;
			rresp    <= tart_pkg::RESP_OKAY;
		end
		else
		begin
			case (rd_state)
				tart_pkg::RD_IDLE:
				begin
					if (arready)
					begin
						// Single cycle ready pulse
						arready <= 1'b0;
						if (S_AXI_ARVALID)
						begin
							rresp    <= mux_resp;
							rd_state <= tart_pkg::RD_DATA;
						end
					end
					else if (S_AXI_ARVALID)
					begin
						arready <= 1'b1;
					end
				end
				tart_pkg::RD_DATA:
				begin
					// Data and response hold until taken
					if (S_AXI_RREADY)
					begin
						rd_state <= tart_pkg::RD_IDLE;
					end
				end
				default:
				begin
					rd_state <= tart_pkg::RD_IDLE;
				end
			endcase
		end
	end

	assign S_AXI_ARREADY = arready;
	assign S_AXI_RDATA   = rdata;
	assign S_AXI_RRESP   = rresp;
	assign S_AXI_RVALID  = (rd_state == tart_pkg::RD_DATA);

endmodule

// File: hdl/tart_axi_top.sv
`timescale 1ns/1ns

module tart_axi_top #(
	parameter integer ANTENNAE   = 24,
	parameter integer DATA_WIDTH = 32,
	parameter integer ADDR_WIDTH = 7
)
(
	input  logic                      S_AXI_ACLK,
	input  logic                      S_AXI_ARESETN,
	// Write address and data
	input  logic [ADDR_WIDTH-1:0]     S_AXI_AWADDR,
	input  logic                      S_AXI_AWVALID,
	output logic                      S_AXI_AWREADY,
	input  logic [DATA_WIDTH-1:0]     S_AXI_WDATA,
	input  logic [(DATA_WIDTH/8)-1:0] S_AXI_WSTRB,
	input  logic                      S_AXI_WVALID,
	output logic                      S_AXI_WREADY,
	// Write response
	output tart_pkg::axi_resp_e       S_AXI_BRESP,
	output logic                      S_AXI_BVALID,
	input  logic                      S_AXI_BREADY,
	// Read address and data
	input  logic [ADDR_WIDTH-1:0]     S_AXI_ARADDR,
	input  logic                      S_AXI_ARVALID,
	output logic                      S_AXI_ARREADY,
	output logic [DATA_WIDTH-1:0]     S_AXI_RDATA,
	output tart_pkg::axi_resp_e       S_AXI_RRESP,
	output logic                      S_AXI_RVALID,
	input  logic                      S_AXI_RREADY,
	// Receiver side
	input  logic [ANTENNAE-1:0]       antenna,
	input  logic                      sample_tick,
	output logic                      led
);

	logic                  capture_enable;
	logic                  count_clear;
	logic [DATA_WIDTH-1:0] ctrl_value;
	logic [DATA_WIDTH-1:0] scratch_value;
	logic [ANTENNAE-1:0]   snapshot;
	logic [DATA_WIDTH-1:0] sample_count;

	// Status LED straight from CONTROL
	assign led = ctrl_value[tart_pkg::CTRL_LED_BIT];

	// ------------------------------------------------------------------------
	// Control and scratch registers
	// ------------------------------------------------------------------------

	axi_write_channel #(
		.DATA_WIDTH (DATA_WIDTH),
		.ADDR_WIDTH (ADDR_WIDTH)
	) u_write (
		.S_AXI_ACLK     (S_AXI_ACLK),
		.S_AXI_ARESETN  (S_AXI_ARESETN),
		.S_AXI_AWADDR   (S_AXI_AWADDR),
		.S_AXI_AWVALID  (S_AXI_AWVALID),
		.S_AXI_AWREADY  (S_AXI_AWREADY),
		.S_AXI_WDATA    (S_AXI_WDATA),
		.S_AXI_WSTRB    (S_AXI_WSTRB),
		.S_AXI_WVALID   (S_AXI_WVALID),
		.S_AXI_WREADY   (S_AXI_WREADY),
		.S_AXI_BRESP    (S_AXI_BRESP),
		.S_AXI_BVALID   (S_AXI_BVALID),
		.S_AXI_BREADY   (S_AXI_BREADY),
		.capture_enable (capture_enable),
		.count_clear    (count_clear),
		.ctrl_value     (ctrl_value),
		.scratch_value  (scratch_value)
	);

	// Snapshot capture in the bus clock domain
	antenna_capture #(
		.ANTENNAE   (ANTENNAE),
		.DATA_WIDTH (DATA_WIDTH)
	) u_capture (
		.S_AXI_ACLK     (S_AXI_ACLK),
		.S_AXI_ARESETN  (S_AXI_ARESETN),
		.antenna        (antenna),
		.sample_tick    (sample_tick),
		.capture_enable (capture_enable),
		.count_clear    (count_clear),
		.snapshot       (snapshot),
		.sample_count   (sample_count)
	);

	// ------------------------------------------------------------------------
	// Read path
	// ------------------------------------------------------------------------

	axi_read_channel #(
		.ANTENNAE   (ANTENNAE),
		.DATA_WIDTH (DATA_WIDTH),
		.ADDR_WIDTH (ADDR_WIDTH)
	) u_read (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.S_AXI_ARADDR  (S_AXI_ARADDR),
		.S_AXI_ARVALID (S_AXI_ARVALID),
		.S_AXI_ARREADY (S_AXI_ARREADY),
		.S_AXI_RDATA   (S_AXI_RDATA),
		.S_AXI_RRESP   (S_AXI_RRESP),
		.S_AXI_RVALID  (S_AXI_RVALID),
		.S_AXI_RREADY  (S_AXI_RREADY),
		.ctrl_value    (ctrl_value),
		.scratch_value (scratch_value),
		.snapshot      (snapshot),
		.sample_count  (sample_count)
	);

endmodule

// File: test/tb_tart_axi_tasks.svh
`ifndef TB_TART_AXI_TASKS_SVH
`define TB_TART_AXI_TASKS_SVH

// ----------------------------------------------------------------------------
// AXI4-Lite master tasks
// ----------------------------------------------------------------------------

// Sampled right after the clock edge, so values are those before the edge
task automatic axi_write(
	input  logic [4:0]            word,
	input  logic [DATA_WIDTH-1:0] data,
	input  logic [STRB_WIDTH-1:0] strb,
	output tart_pkg::axi_resp_e   resp
);
	int          waited;
	logic [31:0] delay;
	random_bits(delay_bits, delay);
	@(posedge S_AXI_ACLK);
	S_AXI_AWADDR  <= {word, 2'b00};
	S_AXI_AWVALID <= 1'b1;
	S_AXI_WDATA   <= data;
	S_AXI_WSTRB   <= strb;
	S_AXI_WVALID  <= 1'b1;
	waited = 0;
	@(posedge S_AXI_ACLK);
	// Address and data are accepted together
	while (!(S_AXI_AWREADY && S_AXI_WREADY))
	begin
		if (waited == TIMEOUT)
		begin
			stop_on_failure("Timeout waiting for AWREADY and WREADY");
		end
		waited++;
		@(posedge S_AXI_ACLK);
	end
	S_AXI_AWVALID <= 1'b0;
	S_AXI_WVALID  <= 1'b0;
	waited = 0;
	while (!S_AXI_BVALID)
	begin
		if (waited == TIMEOUT)
		begin
			stop_on_failure("Timeout waiting for BVALID");
		end
		waited++;
		@(posedge S_AXI_ACLK);
	end
	// Back-pressure, BVALID must stay up
	repeat (delay)
	begin
		@(posedge S_AXI_ACLK);
		if (!S_AXI_BVALID)
		begin
			stop_on_failure("BVALID dropped while BREADY was low");
		end
	end
	S_AXI_BREADY <= 1'b1;
	@(posedge S_AXI_ACLK);
	if (!S_AXI_BVALID)
	begin
		stop_on_failure("BVALID dropped before the response was taken");
	end
	resp = S_AXI_BRESP;
	S_AXI_BREADY <= 1'b0;
endtask

task automatic axi_read(
	input  logic [4:0]            word,
	output logic [DATA_WIDTH-1:0] data,
	output tart_pkg::axi_resp_e   resp
);
	int          waited;
	logic [31:0] delay;
	random_bits(delay_bits, delay);
	@(posedge S_AXI_ACLK);
	S_AXI_ARADDR  <= {word, 2'b00};
	S_AXI_ARVALID <= 1'b1;
	waited = 0;
	@(posedge S_AXI_ACLK);
	while (!S_AXI_ARREADY)
	begin
		if (waited == TIMEOUT)
		begin
			stop_on_failure("Timeout waiting for ARREADY");
		end
		waited++;
		@(posedge S_AXI_ACLK);
	end
	S_AXI_ARVALID <= 1'b0;
	waited = 0;
	while (!S_AXI_RVALID)
	begin
		if (waited == TIMEOUT)
		begin
			stop_on_failure("Timeout waiting for RVALID");
		end
		waited++;
		@(posedge S_AXI_ACLK);
	end
	// RVALID holds with its data until RREADY
	repeat (delay)
	begin
		@(posedge S_AXI_ACLK);
		if (!S_AXI_RVALID)
		begin
			stop_on_failure("RVALID dropped while RREADY was low");
		end
	end
	S_AXI_RREADY <= 1'b1;
	@(posedge S_AXI_ACLK);
	if (!S_AXI_RVALID)
	begin
		stop_on_failure("RVALID dropped before the data was taken");
	end
	data = S_AXI_RDATA;
	resp = S_AXI_RRESP;
	S_AXI_RREADY <= 1'b0;
endtask

// ----------------------------------------------------------------------------
// Compare tasks
// ----------------------------------------------------------------------------

task automatic check_resp(
	input string               name,
	input tart_pkg::axi_resp_e expected,
	input tart_pkg::axi_resp_e actual
);
	if (actual !== expected)
	begin
		stop_on_failure($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
	end
endtask

task automatic check_data(
	input string                 name,
	input logic [DATA_WIDTH-1:0] expected,
	input logic [DATA_WIDTH-1:0] actual
);
	if (actual !== expected)
	begin
		stop_on_failure($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
	end
endtask

task automatic check_led(input string name, input logic expected, input logic actual);
	if (actual !== expected)
	begin
		stop_on_failure($sformatf("[FAIL] %s expected %b actual %b", name, expected, actual));
	end
endtask

`endif

// File: test/tb_tart_axi.sv
`timescale 1ns/1ns

module tb_tart_axi;

	localparam integer ANTENNAE   = 24;
	localparam integer DATA_WIDTH = 32;
	localparam integer ADDR_WIDTH = 7;
	localparam integer STRB_WIDTH = DATA_WIDTH / 8;
	// Longest any single handshake wait may take, in cycles
	localparam integer TIMEOUT    = 200;

	logic                  S_AXI_ACLK;
	logic                  S_AXI_ARESETN;
	logic [ADDR_WIDTH-1:0] S_AXI_AWADDR;
	logic                  S_AXI_AWVALID;
	logic                  S_AXI_AWREADY;
	logic [DATA_WIDTH-1:0] S_AXI_WDATA;
	logic [STRB_WIDTH-1:0] S_AXI_WSTRB;
	logic                  S_AXI_WVALID;
	logic                  S_AXI_WREADY;
	tart_pkg::axi_resp_e   S_AXI_BRESP;
	logic                  S_AXI_BVALID;
	logic                  S_AXI_BREADY;
	logic [ADDR_WIDTH-1:0] S_AXI_ARADDR;
	logic                  S_AXI_ARVALID;
	logic                  S_AXI_ARREADY;
	logic [DATA_WIDTH-1:0] S_AXI_RDATA;
	tart_pkg::axi_resp_e   S_AXI_RRESP;
	logic                  S_AXI_RVALID;
	logic                  S_AXI_RREADY;
	logic [ANTENNAE-1:0]   antenna;
	logic                  sample_tick;
	logic                  led;

	// Reference model state
	logic [DATA_WIDTH-1:0] m_ctrl;
	logic [DATA_WIDTH-1:0] m_scratch;
	logic [DATA_WIDTH-1:0] m_count;
	logic [ANTENNAE-1:0]   m_snapshot;
	// LFSR state and the width of random BREADY and RREADY delays
	logic [31:0]           lfsr_state;
	int                    delay_bits;

	tart_axi_top dut (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.S_AXI_AWADDR  (S_AXI_AWADDR),
		.S_AXI_AWVALID (S_AXI_AWVALID),
		.S_AXI_AWREADY (S_AXI_AWREADY),
		.S_AXI_WDATA   (S_AXI_WDATA),
		.S_AXI_WSTRB   (S_AXI_WSTRB),
		.S_AXI_WVALID  (S_AXI_WVALID),
		.S_AXI_WREADY  (S_AXI_WREADY),
		.S_AXI_BRESP   (S_AXI_BRESP),
		.S_AXI_BVALID  (S_AXI_BVALID),
		.S_AXI_BREADY  (S_AXI_BREADY),
		.S_AXI_ARADDR  (S_AXI_ARADDR),
		.S_AXI_ARVALID (S_AXI_ARVALID),
		.S_AXI_ARREADY (S_AXI_ARREADY),
		.S_AXI_RDATA   (S_AXI_RDATA),
		.S_AXI_RRESP   (S_AXI_RRESP),
		.S_AXI_RVALID  (S_AXI_RVALID),
		.S_AXI_RREADY  (S_AXI_RREADY),
		.antenna       (antenna),
		.sample_tick   (sample_tick),
		.led           (led)
	);

	// 20 ns bus clock
	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever
		begin
			#10 S_AXI_ACLK = ~S_AXI_ACLK;
		end
	end

	// Print the reason, then end the run at the first error
	task automatic stop_on_failure(input string reason);
		$display("%s", reason);
		$display("TESTBENCH FAILED");
		$fatal(1, "Simulation stopped at first error");
	endtask

	`include "tb_tart_axi_tasks.svh"

	// ------------------------------------------------------------------------
	// Random numbers
	// ------------------------------------------------------------------------

	// Galois LFSR, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		if (state[0])
		begin
			return (state >> 1) ^ 32'h8020_0003;
		end
		return state >> 1;
	endfunction

	// One LFSR step per bit taken, MSB first
	task automatic random_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			value      = {value[30:0], lfsr_state[0]};
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	// ------------------------------------------------------------------------
	// Reference model
	// ------------------------------------------------------------------------

	// Each strobe bit covers one byte lane
	function automatic logic [DATA_WIDTH-1:0] strobe_mask(input logic [STRB_WIDTH-1:0] strb);
		logic [DATA_WIDTH-1:0] mask;
		for (int i = 0; i < DATA_WIDTH; i++)
		begin
			mask[i] = strb[i / 8];
		end
		return mask;
	endfunction

	task automatic model_write(
		input logic [4:0]            word,
		input logic [DATA_WIDTH-1:0] data,
		input logic [STRB_WIDTH-1:0] strb
	);
		logic [DATA_WIDTH-1:0] mask;
		mask = strobe_mask(strb);
		if (word == tart_pkg::REG_CONTROL)
		begin
			m_ctrl = (m_ctrl & ~mask) | (data & mask);
			// CLEAR is a pulse and never reads back
			m_ctrl[tart_pkg::CTRL_CLEAR_BIT] = 1'b0;
			if (mask[tart_pkg::CTRL_CLEAR_BIT] && data[tart_pkg::CTRL_CLEAR_BIT])
			begin
				m_count = '0;
			end
		end
		else if (word == tart_pkg::REG_SCRATCH)
		begin
			m_scratch = (m_scratch & ~mask) | (data & mask);
		end
	endtask

	// Unmapped words read as zero
	function automatic logic [DATA_WIDTH-1:0] expected_data(input logic [4:0] word);
		case (word)
			tart_pkg::REG_CONTROL:      return m_ctrl;
			tart_pkg::REG_SAMPLE_COUNT: return m_count;
			tart_pkg::REG_SNAPSHOT:     return {{(DATA_WIDTH-ANTENNAE){1'b0}}, m_snapshot};
			tart_pkg::REG_SCRATCH:      return m_scratch;
			default:                    return '0;
		endcase
	endfunction

	task automatic write_and_check(
		input string                 name,
		input logic [4:0]            word,
		input logic [DATA_WIDTH-1:0] data,
		input logic [STRB_WIDTH-1:0] strb
	);
		tart_pkg::axi_resp_e resp;
		tart_pkg::axi_resp_e expected;
		// Only CONTROL and SCRATCH take writes
		expected = (word == tart_pkg::REG_CONTROL || word == tart_pkg::REG_SCRATCH) ?
		           tart_pkg::RESP_OKAY : tart_pkg::RESP_SLVERR;
		axi_write(word, data, strb, resp);
		model_write(word, data, strb);
		check_resp(name, expected, resp);
		check_led({name, " led"}, m_ctrl[tart_pkg::CTRL_LED_BIT], led);
	endtask

	task automatic read_and_check(input string name, input logic [4:0] word);
		logic [DATA_WIDTH-1:0] data;
		tart_pkg::axi_resp_e   resp;
		tart_pkg::axi_resp_e   expected;
		expected = (word <= 5'd3) ? tart_pkg::RESP_OKAY : tart_pkg::RESP_SLVERR;
		axi_read(word, data, resp);
		check_resp(name, expected, resp);
		check_data(name, expected_data(word), data);
	endtask

	// Single-cycle ticks with random gaps and antenna values
	task automatic run_ticks(input int count);
		logic [31:0] gap;
		logic [31:0] ant;
		for (int i = 0; i < count; i++)
		begin
			random_bits(2, gap);
			random_bits(ANTENNAE, ant);
			repeat (gap)
			begin
				@(posedge S_AXI_ACLK);
			end
			@(posedge S_AXI_ACLK);
			antenna     <= ant[ANTENNAE-1:0];
			sample_tick <= 1'b1;
			@(posedge S_AXI_ACLK);
			sample_tick <= 1'b0;
			if (m_ctrl[tart_pkg::CTRL_CAPTURE_BIT])
			begin
				m_snapshot = ant[ANTENNAE-1:0];
				m_count    = m_count + 1;
			end
		end
	endtask

	// ------------------------------------------------------------------------
	// Test sequence
	// ------------------------------------------------------------------------

	initial
	begin : sequence_main
		logic [31:0] pick;
		logic [31:0] data;
		logic [31:0] strb;
		logic [31:0] ticks;
		logic [4:0]  word;

		S_AXI_ARESETN = 1'b0;
		S_AXI_AWADDR  = '0;
		S_AXI_AWVALID = 1'b0;
		S_AXI_WDATA   = '0;
		S_AXI_WSTRB   = '0;
		S_AXI_WVALID  = 1'b0;
		S_AXI_BREADY  = 1'b0;
		S_AXI_ARADDR  = '0;
		S_AXI_ARVALID = 1'b0;
		S_AXI_RREADY  = 1'b0;
		antenna       = '0;
		sample_tick   = 1'b0;
		m_ctrl        = '0;
		m_scratch     = '0;
		m_count       = '0;
		m_snapshot    = '0;
		lfsr_state    = 32'd43;
		delay_bits    = 3;

		repeat (5)
		begin
			@(posedge S_AXI_ACLK);
		end
		S_AXI_ARESETN <= 1'b1;
		@(posedge S_AXI_ACLK);

		// Everything zero out of reset
		check_led("reset led", 1'b0, led);
		for (int w = 0; w < 4; w++)
		begin
			read_and_check("reset read", 5'(w));
		end

		// Byte-strobed writes to CONTROL and SCRATCH
		for (int i = 0; i < 40; i++)
		begin
			random_bits(1, pick);
			random_bits(32, data);
			random_bits(STRB_WIDTH, strb);
			word = pick[0] ? tart_pkg::REG_SCRATCH : tart_pkg::REG_CONTROL;
			write_and_check("strobed write", word, data, strb[STRB_WIDTH-1:0]);
			read_and_check("strobed readback", word);
		end

		// Read-only and unmapped words reject writes
		for (int i = 0; i < 20; i++)
		begin
			random_bits(5, pick);
			random_bits(32, data);
			word = pick[4:0];
			if (word == tart_pkg::REG_CONTROL || word == tart_pkg::REG_SCRATCH)
			begin
				word = word + 5'd1;
			end
			write_and_check("rejected write", word, data, 4'hF);
			read_and_check("rejected target", word);
			read_and_check("control intact", tart_pkg::REG_CONTROL);
			read_and_check("scratch intact", tart_pkg::REG_SCRATCH);
		end

		// Capture on, then off
		for (int round = 0; round < 3; round++)
		begin
			write_and_check("capture on", tart_pkg::REG_CONTROL, 32'h0000_0003, 4'hF);
			random_bits(4, ticks);
			run_ticks(int'(ticks) + 1);
			read_and_check("tick count", tart_pkg::REG_SAMPLE_COUNT);
			read_and_check("snapshot", tart_pkg::REG_SNAPSHOT);
			write_and_check("capture off", tart_pkg::REG_CONTROL, 32'h0000_0000, 4'h1);
			run_ticks(8);
			read_and_check("idle count", tart_pkg::REG_SAMPLE_COUNT);
			read_and_check("idle snapshot", tart_pkg::REG_SNAPSHOT);
		end

		// CLEAR zeroes the count but the snapshot stays
		write_and_check("clear", tart_pkg::REG_CONTROL, 32'h0000_0006, 4'h1);
		read_and_check("cleared count", tart_pkg::REG_SAMPLE_COUNT);
		read_and_check("kept snapshot", tart_pkg::REG_SNAPSHOT);
		run_ticks(5);
		read_and_check("count after clear", tart_pkg::REG_SAMPLE_COUNT);
		read_and_check("snapshot after clear", tart_pkg::REG_SNAPSHOT);

		// Longer response back-pressure on mixed traffic
		delay_bits = 4;
		for (int i = 0; i < 30; i++)
		begin
			random_bits(1, pick);
			random_bits(5, data);
			word = data[4:0];
			random_bits(32, data);
			random_bits(STRB_WIDTH, strb);
			if (pick[0])
			begin
				write_and_check("stalled write", word, data, strb[STRB_WIDTH-1:0]);
			end
			read_and_check("stalled read", word);
		end

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// File: build.f
+incdir+test
hdl/tart_pkg.sv
hdl/axi_write_channel.sv
hdl/antenna_capture.sv
hdl/axi_read_channel.sv
hdl/tart_axi_top.sv
test/tb_tart_axi.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing -j 0
TOP       = tb_tart_axi
FILELIST  = build.f

.PHONY: sim clean

# Fails unless the run prints the pass message
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "TESTBENCH PASSED"

clean:
	rm -rf obj_dir
